/* Makefile */
TOP := tb_rv_core

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* bench/rv_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_checker #(
    parameter int dmem_addr_w = 18,
    parameter int max_stores  = 32
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            dmem_we,
    input  wire [dmem_addr_w-1:0]          dmem_addr,
    input  wire [rv_pkg::xlen-1:0]         dmem_wdata,
    input  wire                            halted,
    input  wire [rv_pkg::count_w-1:0]      retired,
    input  logic [dmem_addr_w-1:0]         exp_addr [0:max_stores-1],
    input  logic [rv_pkg::xlen-1:0]        exp_data [0:max_stores-1],
    input  int                             exp_stores,
    input  logic [rv_pkg::count_w-1:0]     exp_retired,
    output int                             errors
);
    import rv_pkg::*;

    int   err_cnt  = 0;
    int   idx      = 0; // next expected store
    logic rst_q    = 1'b0;
    logic halted_q = 1'b0;

    assign errors = err_cnt;

    task automatic flag_error(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        err_cnt++;
    endtask

    always @(posedge clk) begin
        rst_q    <= rst;
        halted_q <= halted;
        if (!rst) begin
            idx <= 0;
        end else begin
            if (!rst_q && (halted || dmem_we || retired != '0)) begin
                flag_error("core not idle right after reset");
            end
            if (dmem_we) begin
                if (idx >= exp_stores) begin
                    flag_error($sformatf("unexpected store of %08h to word %0h",
                                         dmem_wdata, dmem_addr));
                end else if (dmem_addr != exp_addr[idx] || dmem_wdata != exp_data[idx]) begin
                    flag_error($sformatf("store %0d wrote %08h to word %0h, expected %08h to %0h",
                                         idx, dmem_wdata, dmem_addr, exp_data[idx], exp_addr[idx]));
                end
                idx <= idx + 1;
            end
            if (halted && !halted_q) begin // first cycle of halt
                if (retired != exp_retired) begin
                    flag_error($sformatf("retired is %0d at halt, expected %0d",
                                         retired, exp_retired));
                end
                if (idx != exp_stores) begin
                    flag_error($sformatf("%0d stores seen at halt, expected %0d",
                                         idx, exp_stores));
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam int mem_words   = 4096;
    localparam int dmem_addr_w = 12;
    localparam int imem_addr_w = 8;
    localparam int n_progs     = 3;
    localparam int max_words   = 64;
    localparam int max_stores  = 32;
    localparam int run_limit   = 2000; // cycles per program
    localparam logic [2:0] f3_word = 3'b010; // lw and sw

    logic                   clk = 1'b0;
    logic                   rst = 1'b0;
    logic [imem_addr_w-1:0] imem_addr;
    instr_t                 imem_data = '0;
    logic [dmem_addr_w-1:0] dmem_addr;
    logic [xlen-1:0]        dmem_wdata;
    logic                   dmem_we;
    logic [xlen-1:0]        dmem_rdata = '0;
    logic                   halted;
    logic [count_w-1:0]     retired;

    logic [31:0] rom [0:(1<<imem_addr_w)-1];
    logic [31:0] ram [0:mem_words-1];

    // program table and expected stores
    logic [31:0]            prog_word [0:n_progs-1][0:max_words-1];
    int                     prog_len  [0:n_progs-1];
    logic [dmem_addr_w-1:0] st_addr   [0:n_progs-1][0:max_stores-1];
    logic [31:0]            st_data   [0:n_progs-1][0:max_stores-1];
    int                     st_cnt    [0:n_progs-1];
    int                     exp_ret   [0:n_progs-1];

    logic [dmem_addr_w-1:0] cur_addr [0:max_stores-1];
    logic [31:0]            cur_data [0:max_stores-1];
    int                     cur_cnt  = 0;
    logic [count_w-1:0]     cur_ret  = '0;
    int                     errors;
    int                     timeouts = 0;
    int                     pg       = 0;
    integer                 seed;

    always #2 clk = ~clk;

    // rom and ram answer one clock after the address
    always @(negedge clk) begin
        imem_data  <= rom[imem_addr];
        dmem_rdata <= ram[dmem_addr];
        if (dmem_we) begin
            ram[dmem_addr] = dmem_wdata;
        end
    end

    rv_core #(
        .mem_words(mem_words),
        .dmem_addr_w(dmem_addr_w),
        .imem_addr_w(imem_addr_w)
    ) UUT (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata), .halted(halted), .retired(retired)
    );

    rv_checker #(.dmem_addr_w(dmem_addr_w), .max_stores(max_stores)) u_checker (
        .clk(clk), .rst(rst), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .halted(halted), .retired(retired),
        .exp_addr(cur_addr), .exp_data(cur_data), .exp_stores(cur_cnt),
        .exp_retired(cur_ret), .errors(errors)
    );

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_op};
    endfunction

    // sw src, word*4(x0)
    function automatic logic [31:0] s_type(input int src, input int word);
        int off;
        off = word * 4;
        return {off[11:5], src[4:0], 5'd0, f3_word, off[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input int rd,
                                           input logic [19:0] imm);
        return {imm, rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog_word[pg][prog_len[pg]] = w;
        prog_len[pg] += 1;
        exp_ret[pg] += 1;
    endtask

    task automatic not_executed(input int k);
        exp_ret[pg] -= k;
    endtask

    task automatic expect_store(input int word, input logic [31:0] data);
        st_addr[pg][st_cnt[pg]] = dmem_addr_w'(word);
        st_data[pg][st_cnt[pg]] = data;
        st_cnt[pg] += 1;
    endtask

    task automatic store_at(input int src, input int word, input logic [31:0] data);
        emit(s_type(src, word));
        expect_store(word, data);
    endtask

    task automatic load_const(input int rd, input logic [31:0] val);
        logic [31:0] hi;
        hi = (val + 32'h800) >> 12; // addi sign-extends the low part
        emit(u_type(op_lui, rd, hi[19:0]));
        emit(i_type(op_imm, f3_add, rd, rd, 32'(val[11:0])));
    endtask

    // taken path skips the not-taken marker
    task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2,
                               input logic taken, input int word);
        emit(b_type(f3, rs1, rs2, 12));
        emit(s_type(8, word));
        emit(j_type(0, 8));
        emit(s_type(9, word));
        expect_store(word, taken ? 32'h0b : 32'h0a);
        not_executed(taken ? 2 : 1);
    endtask

    task automatic alu_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [19:0] upper;
        int          pc;
        a = $random(seed);
        b = $random(seed);
        a[31] = 1'b1; // negative so srai shifts in ones
        load_const(5, a);
        load_const(6, b);
        imm = 12'($random(seed));
        emit(i_type(op_imm, f3_add, 7, 5, 32'(imm)));
        store_at(7, 0, a + sext12(imm));
        sh = 5'($random(seed)) | 5'd1; // never zero
        emit(i_type(op_imm, f3_sll, 7, 5, 32'(sh)));
        store_at(7, 1, a << sh);
        imm = 12'($random(seed));
        emit(i_type(op_imm, f3_xor, 7, 5, 32'(imm)));
        store_at(7, 2, a ^ sext12(imm));
        emit(i_type(op_imm, f3_sra, 7, 5, 32'({7'b0100000, sh})));
        store_at(7, 3, 32'($signed(a) >>> sh));
        imm = 12'($random(seed));
        emit(i_type(op_imm, f3_and, 7, 5, 32'(imm)));
        store_at(7, 4, a & sext12(imm));
        emit(r_type(f7_base, f3_add, 7, 5, 6));
        store_at(7, 5, a + b);
        emit(r_type(f7_alt, f3_add, 7, 5, 6));
        store_at(7, 6, a - b);
        emit(r_type(f7_base, f3_xor, 7, 5, 6));
        store_at(7, 7, a ^ b);
        upper = 20'($random(seed));
        emit(u_type(op_lui, 7, upper));
        store_at(7, 8, {upper, 12'b0});
        pc = prog_len[pg] * 4;
        emit(u_type(op_auipc, 7, upper));
        store_at(7, 9, 32'(pc) + {upper, 12'b0});
        emit(j_type(0, 0)); // halt
    endtask

    task automatic branch_program();
        emit(i_type(op_imm, f3_add, 5, 0, -3));
        emit(i_type(op_imm, f3_add, 6, 0, 5));
        emit(i_type(op_imm, f3_add, 8, 0, 32'h0a)); // not-taken marker
        emit(i_type(op_imm, f3_add, 9, 0, 32'h0b)); // taken marker
        branch_case(f3_beq, 5, 5, 1'b1, 0);
        branch_case(f3_beq, 5, 6, 1'b0, 1);
        branch_case(f3_bne, 5, 6, 1'b1, 2);
        branch_case(f3_bne, 5, 5, 1'b0, 3);
        branch_case(f3_blt, 5, 6, 1'b1, 4);
        branch_case(f3_blt, 6, 5, 1'b0, 5);
        branch_case(f3_bge, 6, 5, 1'b1, 6);
        branch_case(f3_bge, 5, 6, 1'b0, 7); // fails if compared unsigned
        branch_case(f3_bge, 5, 5, 1'b1, 8);
        emit(j_type(0, 0));
    endtask

    task automatic jump_program();
        logic [31:0] c;
        int          pc;
        store_at(2, 0, 32'(mem_words * 4)); // sp preset
        pc = prog_len[pg] * 4;
        emit(j_type(1, 8));
        emit(s_type(2, 1));
        store_at(1, 2, 32'(pc + 4));
        emit(i_type(op_imm, f3_add, 3, 0, 32));
        pc = prog_len[pg] * 4;
        emit(i_type(op_jalr, 3'b000, 4, 3, 4)); // lands on word 9
        emit(s_type(2, 3));
        emit(s_type(2, 3));
        emit(s_type(2, 3));
        store_at(4, 4, 32'(pc + 4));
        not_executed(4);
        c = $random(seed);
        load_const(5, c);
        store_at(5, 64, c);
        emit(i_type(op_load, f3_word, 6, 0, 64 * 4));
        store_at(6, 65, c);
        emit(j_type(0, 0));
    endtask

    task automatic run_program(input int p);
        int cycles;
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < (1 << imem_addr_w); i++) begin
            rom[i] = 32'h0000_006f; // jal x0, 0
        end
        for (int i = 0; i < prog_len[p]; i++) begin
            rom[i] = prog_word[p][i];
        end
        for (int i = 0; i < max_stores; i++) begin
            cur_addr[i] = st_addr[p][i];
            cur_data[i] = st_data[p][i];
        end
        cur_cnt = st_cnt[p];
        cur_ret = count_w'(exp_ret[p]);
        repeat (8) @(negedge clk);
        rst = 1'b1;
        cycles = 0;
        while (!halted && cycles < run_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: program %0d did not halt within %0d cycles", p, run_limit);
            timeouts++;
        end
        repeat (2) @(negedge clk); // checker sees the halt edge
    endtask

    initial begin
        seed = 32'h1652;
        for (int p = 0; p < n_progs; p++) begin
            prog_len[p] = 0;
            st_cnt[p]   = 0;
            exp_ret[p]  = 0;
        end
        pg = 0;
        alu_program();
        pg = 1;
        branch_program();
        pg = 2;
        jump_program();
        for (int i = 0; i < mem_words; i++) begin
            ram[i] = 32'hc0de_0000 ^ 32'(i);
        end
        for (int p = 0; p < n_progs; p++) begin
            run_program(p);
        end
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/rv_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_alu (
    input  wire [6:0]                  opcode,
    input  wire [2:0]                  funct3,
    input  wire [6:0]                  funct7,
    input  wire [rv_pkg::xlen-1:0]     pc,
    input  wire [rv_pkg::xlen-1:0]     rs1_val,
    input  wire [rv_pkg::xlen-1:0]     rs2_val,
    input  wire [rv_pkg::xlen-1:0]     imm_i,
    input  wire [rv_pkg::xlen-1:0]     imm_s,
    input  wire [rv_pkg::xlen-1:0]     imm_u,
    input  wire [rv_pkg::xlen-1:0]     imm_b,
    input  wire [rv_pkg::xlen-1:0]     imm_j,
    input  wire [rv_pkg::xlen-1:0]     shamt,
    output logic [rv_pkg::xlen-1:0]    rd_val,
    output logic [rv_pkg::xlen-1:0]    next_pc,
    output logic [rv_pkg::xlen-1:0]    mem_byte_addr,
    output logic                       writes_rd
);
    import rv_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic            taken;

    assign pc_plus4 = pc + xlen'(4);

    always_comb begin
        case (funct3)
            f3_beq:  taken = (rs1_val == rs2_val);
            f3_bne:  taken = (rs1_val != rs2_val);
            f3_blt:  taken = ($signed(rs1_val) < $signed(rs2_val));
            f3_bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        rd_val        = '0;
        next_pc       = pc_plus4;
        writes_rd     = 1'b1;
        mem_byte_addr = rs1_val + imm_i; // load address by default
        case (opcode)
            op_imm: begin
                case (funct3)
                    f3_add:  rd_val = rs1_val + imm_i;
                    f3_sll:  rd_val = rs1_val << shamt[4:0];
                    f3_xor:  rd_val = rs1_val ^ imm_i;
                    f3_sra:  rd_val = $signed(rs1_val) >>> shamt[4:0];
                    f3_and:  rd_val = rs1_val & imm_i;
                    default: rd_val = '0;
                endcase
            end
            op_op: begin
                if (funct3 == f3_add && funct7 == f7_alt) begin
                    rd_val = rs1_val - rs2_val;
                end else if (funct3 == f3_add && funct7 == f7_base) begin
                    rd_val = rs1_val + rs2_val;
                end else if (funct3 == f3_xor) begin
                    rd_val = rs1_val ^ rs2_val;
                end
            end
            op_lui:   rd_val = imm_u;
            op_auipc: rd_val = pc + imm_u;
            op_jal: begin
                rd_val  = pc_plus4; // link
                next_pc = pc + imm_j;
            end
            op_jalr: begin
                rd_val  = pc_plus4;
                next_pc = (rs1_val + imm_i) & ~xlen'(1);
            end
            op_branch: begin
                writes_rd = 1'b0;
                if (taken) begin
                    next_pc = pc + imm_b;
                end
            end
            op_load:  writes_rd = 1'b1; // data comes from ram
            op_store: begin
                writes_rd     = 1'b0;
                mem_byte_addr = rs1_val + imm_s;
            end
            default:  writes_rd = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_control.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_control #(
    parameter int imem_addr_w = 15,
    parameter int dmem_addr_w = 18
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire [6:0]                      opcode,
    input  wire [rv_pkg::xlen-1:0]         rs1_val,
    input  wire [rv_pkg::xlen-1:0]         rs2_val,
    input  wire [rv_pkg::xlen-1:0]         rd_val,
    input  wire [rv_pkg::xlen-1:0]         next_pc,
    input  wire [rv_pkg::xlen-1:0]         mem_byte_addr,
    input  wire                            writes_rd,
    input  wire [rv_pkg::xlen-1:0]         dmem_rdata,
    output logic [rv_pkg::xlen-1:0]        pc,
    output logic [rv_pkg::xlen-1:0]        op_a,
    output logic [rv_pkg::xlen-1:0]        op_b,
    output logic [imem_addr_w-1:0]         imem_addr,
    output logic [dmem_addr_w-1:0]         dmem_addr,
    output logic [rv_pkg::xlen-1:0]        dmem_wdata,
    output logic                           dmem_we,
    output logic                           reg_we,
    output logic [rv_pkg::xlen-1:0]        rd_data,
    output logic                           halted,
    output logic [rv_pkg::count_w-1:0]     retired
);
    import rv_pkg::*;

    localparam logic [1:0] st_fetch   = 2'd0;
    localparam logic [1:0] st_operand = 2'd1;
    localparam logic [1:0] st_exec    = 2'd2;
    localparam logic [1:0] st_write   = 2'd3;

    logic [1:0]             state;
    logic [1:0]             wait_cnt;
    logic                   wb_en;
    logic                   exec_done;
    logic [imem_addr_w-1:0] fetch_word;

    assign fetch_word = pc[imem_addr_w+1:2];
    assign reg_we     = (state == st_write) && wb_en;

    // ram answers one cycle late, so loads need an extra wait
    always_comb begin
        case (opcode)
            op_load:  exec_done = (wait_cnt == 2'd2);
            op_store: exec_done = (wait_cnt == 2'd1);
            default:  exec_done = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= st_fetch;
            wait_cnt  <= '0;
            wb_en     <= 1'b0;
            pc        <= '0;
            imem_addr <= imem_addr_w'(1); // first fetch never matches
            dmem_addr <= '0;
            dmem_we   <= 1'b0;
            halted    <= 1'b0;
            retired   <= '0;
        end else if (!halted) begin
            case (state)
                st_fetch: begin
                    if (wait_cnt == 2'd0) begin
                        if (fetch_word == imem_addr) begin
                            halted <= 1'b1; // jump to itself
                        end
                        imem_addr <= fetch_word;
                        wait_cnt  <= 2'd1;
                    end else begin
                        wait_cnt <= 2'd0;
                        retired  <= retired + 1'b1;
                        state    <= st_operand;
                    end
                end
                st_operand: begin
                    op_a  <= rs1_val;
                    op_b  <= rs2_val;
                    state <= st_exec;
                end
                st_exec: begin
                    if (exec_done) begin
                        pc       <= next_pc;
                        wb_en    <= writes_rd;
                        rd_data  <= (opcode == op_load) ? dmem_rdata : rd_val;
                        dmem_we  <= 1'b0;
                        wait_cnt <= 2'd0;
                        state    <= st_write;
                    end else begin
                        wait_cnt <= wait_cnt + 2'd1;
                        if (wait_cnt == 2'd0) begin
                            dmem_addr  <= mem_byte_addr[dmem_addr_w+1:2];
                            dmem_wdata <= op_b;
                            dmem_we    <= (opcode == op_store);
                        end
                    end
                end
                default: begin
                    wb_en <= 1'b0;
                    state <= st_fetch;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
    parameter int mem_words   = 262144,
    parameter int dmem_addr_w = 18,
    parameter int imem_addr_w = 15
) (
    input  wire                            clk,
    input  wire                            rst,
    output logic [imem_addr_w-1:0]         imem_addr,
    input  wire rv_pkg::instr_t            imem_data,
    output logic [dmem_addr_w-1:0]         dmem_addr,
    output logic [rv_pkg::xlen-1:0]        dmem_wdata,
    output logic                           dmem_we,
    input  wire [rv_pkg::xlen-1:0]         dmem_rdata,
    output logic                           halted,
    output logic [rv_pkg::count_w-1:0]     retired
);
    import rv_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs1, rs2, rd;
    logic [xlen-1:0]       imm_i, imm_s, imm_u, imm_b, imm_j, shamt;
    logic [xlen-1:0]       rs1_val, rs2_val;
    logic [xlen-1:0]       op_a, op_b, pc;
    logic [xlen-1:0]       rd_val, next_pc, mem_byte_addr;
    logic                  writes_rd;
    logic                  reg_we;
    logic [xlen-1:0]       rd_data;

    rv_decode u_decode (
        .instr(imem_data), .opcode(opcode), .funct3(funct3), .funct7(funct7),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm_i(imm_i), .imm_s(imm_s), .imm_u(imm_u), .imm_b(imm_b), .imm_j(imm_j),
        .shamt(shamt)
    );

    rv_regfile #(.mem_words(mem_words)) u_regfile (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(reg_we), .wdata(rd_data), .rs1_val(rs1_val), .rs2_val(rs2_val)
    );

    rv_alu u_alu (
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .pc(pc),
        .rs1_val(op_a), .rs2_val(op_b), // latched operands
        .imm_i(imm_i), .imm_s(imm_s), .imm_u(imm_u), .imm_b(imm_b), .imm_j(imm_j),
        .shamt(shamt), .rd_val(rd_val), .next_pc(next_pc),
        .mem_byte_addr(mem_byte_addr), .writes_rd(writes_rd)
    );

    rv_control #(
        .imem_addr_w(imem_addr_w),
        .dmem_addr_w(dmem_addr_w)
    ) u_control (
        .clk(clk), .rst(rst), .opcode(opcode),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .rd_val(rd_val), .next_pc(next_pc),
        .mem_byte_addr(mem_byte_addr), .writes_rd(writes_rd), .dmem_rdata(dmem_rdata),
        .pc(pc), .op_a(op_a), .op_b(op_b),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .reg_we(reg_we), .rd_data(rd_data),
        .halted(halted), .retired(retired)
    );

endmodule

`default_nettype wire

/* source/rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
    input  wire rv_pkg::instr_t                 instr,
    output logic [6:0]                          opcode,
    output logic [2:0]                          funct3,
    output logic [6:0]                          funct7,
    output logic [rv_pkg::reg_addr_w-1:0]       rs1,
    output logic [rv_pkg::reg_addr_w-1:0]       rs2,
    output logic [rv_pkg::reg_addr_w-1:0]       rd,
    output logic [rv_pkg::xlen-1:0]             imm_i,
    output logic [rv_pkg::xlen-1:0]             imm_s,
    output logic [rv_pkg::xlen-1:0]             imm_u,
    output logic [rv_pkg::xlen-1:0]             imm_b,
    output logic [rv_pkg::xlen-1:0]             imm_j,
    output logic [rv_pkg::xlen-1:0]             shamt
);
    import rv_pkg::*;

    logic sign;

    assign sign = instr.r.funct7[6]; // top bit of every format

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;
    assign rs1    = instr.r.rs1;
    assign rs2    = instr.r.rs2;
    assign rd     = instr.r.rd;

    assign imm_i = {{(xlen-12){sign}}, instr.i.imm};
    assign imm_s = {{(xlen-12){sign}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_u = {instr.u.imm, 12'b0};
    assign imm_b = {{(xlen-13){sign}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_j = {{(xlen-21){sign}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    assign shamt = {{(xlen-5){1'b0}}, instr.r.rs2}; // shift amount sits in rs2 slot

endmodule

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int count_w    = 40;
    localparam int reg_addr_w = 5;

    // major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_sra = 3'b101;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub

    // one instruction word, six format views
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
        struct packed {
            logic [19:0]           imm;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } u;
        struct packed {
            logic                  imm12;
            logic [5:0]            imm10_5;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [3:0]            imm4_1;
            logic                  imm11;
            logic [6:0]            opcode;
        } b;
        struct packed {
            logic                  imm20;
            logic [9:0]            imm10_1;
            logic                  imm11;
            logic [7:0]            imm19_12;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } j;
    } instr_t;

endpackage

`default_nettype wire

/* source/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile #(
    parameter int mem_words = 262144
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire [rv_pkg::reg_addr_w-1:0]   rs1,
    input  wire [rv_pkg::reg_addr_w-1:0]   rs2,
    input  wire [rv_pkg::reg_addr_w-1:0]   rd,
    input  wire                            we,
    input  wire [rv_pkg::xlen-1:0]         wdata,
    output logic [rv_pkg::xlen-1:0]        rs1_val,
    output logic [rv_pkg::xlen-1:0]        rs2_val
);
    import rv_pkg::*;

    logic signed [xlen-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (!rst) begin
            regs[0] <= '0;
            regs[2] <= xlen'(mem_words * 4); // sp at top of data ram
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];

endmodule

`default_nettype wire

/* tb.f */
source/rv_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_control.sv
source/rv_core.sv
bench/rv_checker.sv
bench/tb_rv_core.sv
